// ==== Makefile ====
VERILATOR ?= verilator
FLAGS     ?= --timing
TOP       ?= commit_core_tb
FILELIST  ?= commit_core.f
LOG       ?= sim.log

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(FLAGS) --top-module $(TOP) -f $(FILELIST)

sim:
	$(VERILATOR) --binary $(FLAGS) --top-module $(TOP) -f $(FILELIST)
	./obj_dir/V$(TOP) | tee $(LOG)
	grep -q "PASS: all tests" $(LOG)

clean:
	rm -rf obj_dir $(LOG)

// ==== commit_core.f ====
+incdir+common
common/rv32i_pkg.sv
common/ooo_pkg.sv
src/reorder_buffer/reorder_buffer.sv
src/store_commit.sv
src/redirect_unit.sv
src/commit_core.sv
tests/commit_core_tb.sv

// ==== common/ooo_consts.svh ====
`ifndef OOO_CONSTS_SVH
`define OOO_CONSTS_SVH

// usable reorder buffer entries, tags run 1..ROB_DEPTH
`define ROB_DEPTH 8

// wide enough for tags 0..ROB_DEPTH, tag 0 is "no entry"
`define ROB_TAG_W 4

// number of ALU result buses
`define NUM_ALU 2

// data and address width
`define XLEN 32

`endif

// ==== common/ooo_pkg.sv ====
`include "ooo_consts.svh"

package ooo_pkg;

    // reorder buffer entry number, 0 means none
    typedef logic [`ROB_TAG_W-1:0] tag_t;

    // what an entry does when it retires
    typedef enum logic [1:0] {
        // register result, includes loads and slt
        OP_REG  = 2'd0,
        OP_ST   = 2'd1,
        OP_BR   = 2'd2,
        OP_JALR = 2'd3
    } rob_op_t;

endpackage

// ==== common/rv32i_pkg.sv ====
`include "ooo_consts.svh"

package rv32i_pkg;

    // data or address word
    typedef logic [`XLEN-1:0] word_t;

    // architectural register index, x0..x31
    typedef logic [4:0] reg_idx_t;

endpackage

// ==== src/commit_core.sv ====
`timescale 1ns/1ns
`include "ooo_consts.svh"

module commit_core (
    input  logic                    clk,
    input  logic                    rst_n,
    input  logic                    valid_in,
    input  ooo_pkg::rob_op_t        op_type,
    input  rv32i_pkg::word_t        dest,
    output ooo_pkg::tag_t           alloc_tag,
    input  logic [`NUM_ALU-1:0]     alu_valid,
    input  ooo_pkg::tag_t           alu_tag [`NUM_ALU],
    input  rv32i_pkg::word_t        alu_val [`NUM_ALU],
    input  logic                    cmp_valid,
    input  ooo_pkg::tag_t           cmp_tag,
    input  logic                    cmp_ok,
    input  rv32i_pkg::word_t        cmp_val,
    input  rv32i_pkg::word_t        cmp_pc_next,
    input  logic                    ls_valid,
    input  ooo_pkg::tag_t           ls_tag,
    input  rv32i_pkg::word_t        ls_val,
    input  rv32i_pkg::word_t        ls_addr,
    input  logic                    jalr_valid,
    input  ooo_pkg::tag_t           jalr_tag,
    input  logic                    jalr_ok,
    input  rv32i_pkg::word_t        jalr_val,
    input  rv32i_pkg::word_t        jalr_pc_next,
    input  ooo_pkg::tag_t           src_tag,
    output logic                    src_ready,
    output rv32i_pkg::word_t        src_val,
    output logic                    rf_we,
    output rv32i_pkg::reg_idx_t     rf_rd,
    output rv32i_pkg::word_t        rf_val,
    output ooo_pkg::tag_t           rf_tag,
    output logic                    mem_write,
    output rv32i_pkg::word_t        mem_addr,
    output rv32i_pkg::word_t        mem_wdata,
    output logic                    new_store,
    input  logic                    mem_resp,
    output logic                    flush,
    output logic                    br_mispredict,
    output logic                    jalr_mispredict,
    output rv32i_pkg::word_t        pc_correct,
    output rv32i_pkg::word_t        mispredict_pc
);

    logic               head_ready;
    ooo_pkg::rob_op_t   head_op;
    rv32i_pkg::word_t   head_dest;
    rv32i_pkg::word_t   head_val;
    logic               head_ok;
    logic               store_req;
    logic               store_done;

    reorder_buffer i_reorder_buffer (
        .clk          (clk),
        .rst_n        (rst_n),
        .flush        (flush),
        .store_done   (store_done),
        .valid_in     (valid_in),
        .op_type      (op_type),
        .dest         (dest),
        .alu_valid    (alu_valid),
        .alu_tag      (alu_tag),
        .alu_val      (alu_val),
        .cmp_valid    (cmp_valid),
        .cmp_tag      (cmp_tag),
        .cmp_ok       (cmp_ok),
        .cmp_val      (cmp_val),
        .cmp_pc_next  (cmp_pc_next),
        .ls_valid     (ls_valid),
        .ls_tag       (ls_tag),
        .ls_val       (ls_val),
        .ls_addr      (ls_addr),
        .jalr_valid   (jalr_valid),
        .jalr_tag     (jalr_tag),
        .jalr_ok      (jalr_ok),
        .jalr_val     (jalr_val),
        .jalr_pc_next (jalr_pc_next),
        .src_tag      (src_tag),
        .src_ready    (src_ready),
        .src_val      (src_val),
        .alloc_tag    (alloc_tag),
        .head_ready   (head_ready),
        .head_op      (head_op),
        .head_dest    (head_dest),
        .head_val     (head_val),
        .head_ok      (head_ok),
        .store_req    (store_req),
        .rf_we        (rf_we),
        .rf_rd        (rf_rd),
        .rf_val       (rf_val),
        .rf_tag       (rf_tag)
    );

    store_commit i_store_commit (
        .clk        (clk),
        .rst_n      (rst_n),
        .flush      (flush),
        .store_req  (store_req),
        .head_dest  (head_dest),
        .head_val   (head_val),
        .mem_resp   (mem_resp),
        .mem_write  (mem_write),
        .mem_addr   (mem_addr),
        .mem_wdata  (mem_wdata),
        .new_store  (new_store),
        .store_done (store_done)
    );

    redirect_unit i_redirect_unit (
        .head_ready      (head_ready),
        .head_op         (head_op),
        .head_ok         (head_ok),
        .head_dest       (head_dest),
        .head_val        (head_val),
        .flush           (flush),
        .br_mispredict   (br_mispredict),
        .jalr_mispredict (jalr_mispredict),
        .pc_correct      (pc_correct),
        .mispredict_pc   (mispredict_pc)
    );

endmodule

// ==== src/redirect_unit.sv ====
`timescale 1ns/1ns

module redirect_unit (
    input  logic                head_ready,
    input  ooo_pkg::rob_op_t    head_op,
    input  logic                head_ok,
    input  rv32i_pkg::word_t    head_dest,
    input  rv32i_pkg::word_t    head_val,
    output logic                flush,
    output logic                br_mispredict,
    output logic                jalr_mispredict,
    output rv32i_pkg::word_t    pc_correct,
    output rv32i_pkg::word_t    mispredict_pc
);

    logic wrong_path;

    // only control transfers carry a meaningful ok bit
    assign wrong_path = head_ready && !head_ok;

    always_comb begin
        br_mispredict   = 1'b0;
        jalr_mispredict = 1'b0;
        if (wrong_path) begin
            br_mispredict   = (head_op == ooo_pkg::OP_BR);
            jalr_mispredict = (head_op == ooo_pkg::OP_JALR);
        end
    end

    assign flush = br_mispredict || jalr_mispredict;

    // head_dest holds the corrected target, head_val the faulting pc
    assign pc_correct    = flush ? head_dest : '0;
    assign mispredict_pc = flush ? head_val : '0;

endmodule

// ==== src/reorder_buffer/reorder_buffer.sv ====
`timescale 1ns/1ns
`include "ooo_consts.svh"

module reorder_buffer (
    input  logic                    clk,
    input  logic                    rst_n,
    input  logic                    flush,
    input  logic                    store_done,
    // allocation from the decoder
    input  logic                    valid_in,
    input  ooo_pkg::rob_op_t        op_type,
    input  rv32i_pkg::word_t        dest,
    // ALU result buses
    input  logic [`NUM_ALU-1:0]     alu_valid,
    input  ooo_pkg::tag_t           alu_tag [`NUM_ALU],
    input  rv32i_pkg::word_t        alu_val [`NUM_ALU],
    // compare / branch result bus
    input  logic                    cmp_valid,
    input  ooo_pkg::tag_t           cmp_tag,
    input  logic                    cmp_ok,
    input  rv32i_pkg::word_t        cmp_val,
    input  rv32i_pkg::word_t        cmp_pc_next,
    // load / store result bus
    input  logic                    ls_valid,
    input  ooo_pkg::tag_t           ls_tag,
    input  rv32i_pkg::word_t        ls_val,
    input  rv32i_pkg::word_t        ls_addr,
    // jalr result bus
    input  logic                    jalr_valid,
    input  ooo_pkg::tag_t           jalr_tag,
    input  logic                    jalr_ok,
    input  rv32i_pkg::word_t        jalr_val,
    input  rv32i_pkg::word_t        jalr_pc_next,
    // operand read port
    input  ooo_pkg::tag_t           src_tag,
    output logic                    src_ready,
    output rv32i_pkg::word_t        src_val,
    output ooo_pkg::tag_t           alloc_tag,
    // head entry
    output logic                    head_ready,
    output ooo_pkg::rob_op_t        head_op,
    output rv32i_pkg::word_t        head_dest,
    output rv32i_pkg::word_t        head_val,
    output logic                    head_ok,
    output logic                    store_req,
    // register file write
    output logic                    rf_we,
    output rv32i_pkg::reg_idx_t     rf_rd,
    output rv32i_pkg::word_t        rf_val,
    output ooo_pkg::tag_t           rf_tag
);

    // slot 0 is never allocated so that tag 0 always reads as not ready
    logic               busy  [0:`ROB_DEPTH];
    logic               ready [0:`ROB_DEPTH];
    ooo_pkg::rob_op_t   op    [0:`ROB_DEPTH];
    // rd index for register ops, address for stores, correct pc on a mispredict
    rv32i_pkg::word_t   dst   [0:`ROB_DEPTH];
    rv32i_pkg::word_t   val   [0:`ROB_DEPTH];
    logic               ok    [0:`ROB_DEPTH];

    ooo_pkg::tag_t      in_ptr;
    ooo_pkg::tag_t      commit_ptr;
    logic               retire;

    function automatic ooo_pkg::tag_t next_tag(input ooo_pkg::tag_t t);
        if (t == ooo_pkg::tag_t'(`ROB_DEPTH)) begin
            return ooo_pkg::tag_t'(1);
        end
        return t + ooo_pkg::tag_t'(1);
    endfunction

    assign head_ready = ready[commit_ptr];
    assign head_op    = op[commit_ptr];
    assign head_dest  = dst[commit_ptr];
    assign head_val   = val[commit_ptr];
    assign head_ok    = ok[commit_ptr];

    assign store_req = head_ready && (head_op == ooo_pkg::OP_ST);

    // a store leaves only once the cache has acknowledged it
    assign retire = head_ready && ((head_op != ooo_pkg::OP_ST) || store_done);

    // full when the slot under the input pointer has not retired yet
    assign alloc_tag = busy[in_ptr] ? '0 : in_ptr;

    always_ff @(posedge clk) begin
        if (!rst_n || flush) begin
            for (int i = 0; i <= `ROB_DEPTH; i++) begin
                busy[i]  <= 1'b0;
                ready[i] <= 1'b0;
            end
            in_ptr     <= ooo_pkg::tag_t'(1);
            commit_ptr <= ooo_pkg::tag_t'(1);
        end else begin
            if (retire) begin
                busy[commit_ptr]  <= 1'b0;
                ready[commit_ptr] <= 1'b0;
                commit_ptr        <= next_tag(commit_ptr);
            end

            if (valid_in) begin
                busy[in_ptr]  <= 1'b1;
                ready[in_ptr] <= 1'b0;
                op[in_ptr]    <= op_type;
                dst[in_ptr]   <= dest;
                // assume correct until a compare or jalr result says otherwise
                ok[in_ptr]    <= 1'b1;
                in_ptr        <= next_tag(in_ptr);
            end

            for (int j = 0; j < `NUM_ALU; j++) begin
                if (alu_valid[j] && busy[alu_tag[j]]) begin
                    val[alu_tag[j]]   <= alu_val[j];
                    ready[alu_tag[j]] <= 1'b1;
                end
            end

            if (cmp_valid && busy[cmp_tag]) begin
                ready[cmp_tag] <= 1'b1;
                ok[cmp_tag]    <= cmp_ok;
                // branch pc for a branch, the result for slt
                val[cmp_tag]   <= cmp_val;
                if (!cmp_ok && (op[cmp_tag] == ooo_pkg::OP_BR)) begin
                    dst[cmp_tag] <= cmp_pc_next;
                end
            end

            if (ls_valid && busy[ls_tag]) begin
                ready[ls_tag] <= 1'b1;
                val[ls_tag]   <= ls_val;
                if (op[ls_tag] == ooo_pkg::OP_ST) begin
                    dst[ls_tag] <= ls_addr;
                end
            end

            // target kept per entry, so a later jalr cannot overwrite it
            if (jalr_valid && busy[jalr_tag]) begin
                ready[jalr_tag] <= 1'b1;
                ok[jalr_tag]    <= jalr_ok;
                val[jalr_tag]   <= jalr_val;
                if (!jalr_ok) begin
                    dst[jalr_tag] <= jalr_pc_next;
                end
            end
        end
    end

    // operand read, with ALU results forwarded in their strobe cycle
    always_comb begin
        src_ready = ready[src_tag];
        src_val   = val[src_tag];
        for (int j = 0; j < `NUM_ALU; j++) begin
            if (alu_valid[j] && (alu_tag[j] == src_tag) && (src_tag != '0)) begin
                src_ready = 1'b1;
                src_val   = alu_val[j];
            end
        end
    end

    always_comb begin
        rf_we  = retire && ((head_op == ooo_pkg::OP_REG) ||
                            ((head_op == ooo_pkg::OP_JALR) && head_ok));
        rf_rd  = '0;
        rf_val = '0;
        rf_tag = '0;
        if (rf_we) begin
            rf_rd  = head_dest[4:0];
            rf_val = head_val;
            rf_tag = commit_ptr;
        end
    end

endmodule

// ==== src/store_commit.sv ====
`timescale 1ns/1ns

module store_commit (
    input  logic                clk,
    input  logic                rst_n,
    input  logic                flush,
    input  logic                store_req,
    input  rv32i_pkg::word_t    head_dest,
    input  rv32i_pkg::word_t    head_val,
    input  logic                mem_resp,
    output logic                mem_write,
    output rv32i_pkg::word_t    mem_addr,
    output rv32i_pkg::word_t    mem_wdata,
    output logic                new_store,
    output logic                store_done
);

    typedef enum logic {
        ST_IDLE = 1'b0,
        ST_WAIT = 1'b1
    } state_t;

    state_t state;
    state_t next_state;

    // head cannot move while the store waits, so address and data stay stable
    assign mem_write  = (state == ST_WAIT) || store_req;
    assign new_store  = (state == ST_IDLE) && store_req;
    assign store_done = mem_write && mem_resp;
    assign mem_addr   = mem_write ? head_dest : '0;
    assign mem_wdata  = mem_write ? head_val : '0;

    always_comb begin
        next_state = state;
        case (state)
            ST_IDLE: begin
                // a same-cycle response finishes without leaving idle
                if (store_req && !mem_resp) begin
                    next_state = ST_WAIT;
                end
            end
            ST_WAIT: begin
                if (mem_resp) begin
                    next_state = ST_IDLE;
                end
            end
            default: next_state = ST_IDLE;
        endcase
    end

    always_ff @(posedge clk) begin
        if (!rst_n || flush) begin
            state <= ST_IDLE;
        end else begin
            state <= next_state;
        end
    end

endmodule

// ==== tests/commit_core_tb.sv ====
`timescale 1ns/1ns
`include "ooo_consts.svh"

module commit_core_tb;

    typedef struct packed {
        ooo_pkg::rob_op_t   op;
        rv32i_pkg::word_t   dest;
        rv32i_pkg::word_t   value;
        logic               ok;
        // correct pc for control ops, address for stores
        rv32i_pkg::word_t   pcn;
        // 0 alu0, 1 alu1, 2 cmp, 3 ls, 4 jalr
        logic [2:0]         bus;
        logic [3:0]         order;
        logic [3:0]         grp;
    } row_t;

    localparam int ROWS = 14;
    localparam int GROUPS = 6;
    localparam int LIMIT = 40 * ROWS + 200;

    localparam row_t TABLE [ROWS] = '{
        '{ooo_pkg::OP_REG,  32'd1,  32'd11,         1'b1, 32'h0,    3'd0, 4'd3, 4'd0},
        '{ooo_pkg::OP_REG,  32'd2,  32'd22,         1'b1, 32'h0,    3'd1, 4'd2, 4'd0},
        '{ooo_pkg::OP_REG,  32'd3,  32'd33,         1'b1, 32'h0,    3'd3, 4'd1, 4'd0},
        '{ooo_pkg::OP_REG,  32'd4,  32'd44,         1'b1, 32'h0,    3'd0, 4'd0, 4'd0},
        '{ooo_pkg::OP_ST,   32'd0,  32'hdeadbeef,   1'b1, 32'h1000, 3'd3, 4'd0, 4'd1},
        '{ooo_pkg::OP_REG,  32'd5,  32'd55,         1'b1, 32'h0,    3'd1, 4'd1, 4'd1},
        '{ooo_pkg::OP_BR,   32'd0,  32'h200,        1'b0, 32'h400,  3'd2, 4'd0, 4'd2},
        '{ooo_pkg::OP_REG,  32'd6,  32'd66,         1'b1, 32'h0,    3'd0, 4'd1, 4'd2},
        '{ooo_pkg::OP_BR,   32'd0,  32'h300,        1'b1, 32'h0,    3'd2, 4'd1, 4'd3},
        '{ooo_pkg::OP_REG,  32'd7,  32'd77,         1'b1, 32'h0,    3'd0, 4'd0, 4'd3},
        '{ooo_pkg::OP_JALR, 32'd8,  32'h504,        1'b1, 32'h0,    3'd4, 4'd0, 4'd4},
        '{ooo_pkg::OP_REG,  32'd9,  32'd99,         1'b1, 32'h0,    3'd0, 4'd2, 4'd5},
        '{ooo_pkg::OP_JALR, 32'd10, 32'h604,        1'b0, 32'h800,  3'd4, 4'd0, 4'd5},
        '{ooo_pkg::OP_JALR, 32'd11, 32'h704,        1'b0, 32'h900,  3'd4, 4'd1, 4'd5}
    };

    logic clk, rst_n, valid_in, cmp_valid, cmp_ok, ls_valid, jalr_valid, jalr_ok, mem_resp;
    ooo_pkg::rob_op_t op_type;
    rv32i_pkg::word_t dest, cmp_val, cmp_pc_next, ls_val, ls_addr, jalr_val, jalr_pc_next;
    logic [`NUM_ALU-1:0] alu_valid;
    ooo_pkg::tag_t alu_tag [`NUM_ALU];
    rv32i_pkg::word_t alu_val [`NUM_ALU];
    ooo_pkg::tag_t cmp_tag, ls_tag, jalr_tag, src_tag, alloc_tag, rf_tag;
    logic src_ready, rf_we, mem_write, new_store, flush, br_mispredict, jalr_mispredict;
    rv32i_pkg::word_t src_val, rf_val, mem_addr, mem_wdata, pc_correct, mispredict_pc;
    rv32i_pkg::reg_idx_t rf_rd;

    // kind of each expected event is 0 for a register write, 1 for a store and 2 for a flush
    int exp_kind [$];
    logic [31:0] exp_a [$];
    logic [31:0] exp_b [$];
    logic [31:0] exp_c [$];

    int errors, tests_run, tests_failed, new_store_cnt, cycles, wait_cnt;
    logic [31:0] rng;

    commit_core i_commit_core (.*);

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    function automatic logic [31:0] xorshift(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    task automatic check_val(input string name, input logic [31:0] got, input logic [31:0] exp);
        if (got !== exp) begin
            $display("ERROR t=%0t %s got 0x%0h expected 0x%0h", $time, name, got, exp);
            errors++;
        end
    endtask

    task automatic push_expect(input int kind, input logic [31:0] a, b, c);
        exp_kind.push_back(kind);
        exp_a.push_back(a);
        exp_b.push_back(b);
        exp_c.push_back(c);
    endtask

    task automatic pop_expect();
        void'(exp_kind.pop_front());
        void'(exp_a.pop_front());
        void'(exp_b.pop_front());
        void'(exp_c.pop_front());
    endtask

    function automatic bit front_is(input int kind);
        return (exp_kind.size() != 0) && (exp_kind[0] == kind);
    endfunction

    // checks every retirement side effect against the expected event queue
    always @(posedge clk) begin
        if (rst_n) begin
            if (new_store) new_store_cnt++;
            if (rf_we && !front_is(0)) begin
                $display("ERROR t=%0t unexpected register write to x%0d", $time, rf_rd);
                errors++;
            end else if (rf_we) begin
                check_val("rf_rd", 32'(rf_rd), exp_a[0]);
                check_val("rf_val", rf_val, exp_b[0]);
                check_val("rf_tag", 32'(rf_tag), exp_c[0]);
                pop_expect();
            end
            if (mem_write && mem_resp && !front_is(1)) begin
                $display("ERROR t=%0t store completed out of order", $time);
                errors++;
            end else if (mem_write && mem_resp) begin
                check_val("mem_addr", mem_addr, exp_a[0]);
                check_val("mem_wdata", mem_wdata, exp_b[0]);
                pop_expect();
            end
            if (flush && !front_is(2)) begin
                $display("ERROR t=%0t unexpected flush", $time);
                errors++;
            end else if (flush) begin
                check_val("pc_correct", pc_correct, exp_a[0]);
                check_val("mispredict_pc", mispredict_pc, exp_b[0]);
                check_val("br_mispredict", 32'(br_mispredict), 32'(exp_c[0] == 1));
                check_val("jalr_mispredict", 32'(jalr_mispredict), 32'(exp_c[0] == 2));
                pop_expect();
            end
        end
    end

    // data cache model that answers each store after 1 to 4 cycles
    always @(posedge clk) begin
        if (!rst_n) begin
            mem_resp <= 1'b0;
            wait_cnt = 0;
        end else if (mem_resp) begin
            mem_resp <= 1'b0;
        end else if (mem_write) begin
            if (wait_cnt == 0) begin
                rng = xorshift(rng);
                wait_cnt = int'(rng % 4) + 1;
            end
            wait_cnt = wait_cnt - 1;
            if (wait_cnt == 0) mem_resp <= 1'b1;
        end
    end

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles >= LIMIT) begin
            $display("timeout: run did not finish within %0d cycles", LIMIT);
            $display("FAIL: see errors above");
            $finish;
        end
    end

    task automatic alloc(input ooo_pkg::rob_op_t op, input rv32i_pkg::word_t d,
                         output ooo_pkg::tag_t tag);
        @(posedge clk);
        while (alloc_tag == '0) @(posedge clk);
        tag = alloc_tag;
        valid_in <= 1'b1;
        op_type  <= op;
        dest     <= d;
        @(posedge clk);
        valid_in <= 1'b0;
    endtask

    task automatic send_result(input int bus, input ooo_pkg::tag_t tag,
                               input rv32i_pkg::word_t v, input logic ok,
                               input rv32i_pkg::word_t pcn);
        @(posedge clk);
        case (bus)
            0, 1: begin
                alu_valid[bus] <= 1'b1;
                alu_tag[bus]   <= tag;
                alu_val[bus]   <= v;
            end
            2: begin
                cmp_valid   <= 1'b1;
                cmp_tag     <= tag;
                cmp_ok      <= ok;
                cmp_val     <= v;
                cmp_pc_next <= pcn;
            end
            3: begin
                ls_valid <= 1'b1;
                ls_tag   <= tag;
                ls_val   <= v;
                ls_addr  <= pcn;
            end
            default: begin
                jalr_valid   <= 1'b1;
                jalr_tag     <= tag;
                jalr_ok      <= ok;
                jalr_val     <= v;
                jalr_pc_next <= pcn;
            end
        endcase
        @(posedge clk);
        alu_valid  <= '0;
        cmp_valid  <= 1'b0;
        ls_valid   <= 1'b0;
        jalr_valid <= 1'b0;
    endtask

    task automatic drain();
        while (exp_kind.size() != 0) @(posedge clk);
        @(posedge clk);
    endtask

    task automatic end_test(input string name, input int err_before);
        tests_run++;
        if (errors == err_before) begin
            $display("test %s: ok", name);
        end else begin
            tests_failed++;
            $display("test %s: failed with %0d errors", name, errors - err_before);
        end
    endtask

    task automatic run_group(input int g, input string name);
        ooo_pkg::tag_t tags [ROWS];
        int err_before;
        int stores;
        bit flushed;
        err_before = errors;
        stores = new_store_cnt;
        flushed = 0;
        for (int i = 0; i < ROWS; i++) begin
            if (int'(TABLE[i].grp) == g) alloc(TABLE[i].op, TABLE[i].dest, tags[i]);
        end
        // expected effects in program order up to the first mispredict
        for (int i = 0; i < ROWS; i++) begin
            if (int'(TABLE[i].grp) == g && !flushed) begin
                if (TABLE[i].op == ooo_pkg::OP_REG ||
                    (TABLE[i].op == ooo_pkg::OP_JALR && TABLE[i].ok)) begin
                    push_expect(0, 32'(TABLE[i].dest[4:0]), TABLE[i].value, 32'(tags[i]));
                end else if (TABLE[i].op == ooo_pkg::OP_ST) begin
                    push_expect(1, TABLE[i].pcn, TABLE[i].value, 0);
                    stores++;
                end else if (!TABLE[i].ok) begin
                    push_expect(2, TABLE[i].pcn, TABLE[i].value,
                                (TABLE[i].op == ooo_pkg::OP_BR) ? 1 : 2);
                    flushed = 1;
                end
            end
        end
        for (int o = 0; o < ROWS; o++) begin
            for (int i = 0; i < ROWS; i++) begin
                if (int'(TABLE[i].grp) == g && int'(TABLE[i].order) == o) begin
                    send_result(int'(TABLE[i].bus), tags[i], TABLE[i].value, TABLE[i].ok,
                                TABLE[i].pcn);
                end
            end
        end
        drain();
        check_val("new_store count", new_store_cnt, stores);
        if (flushed) check_val("alloc_tag", 32'(alloc_tag), 1);
        end_test(name, err_before);
    endtask

    initial begin
        ooo_pkg::tag_t ta, tb;
        ooo_pkg::tag_t full_tags [`ROB_DEPTH];
        int err_before;
        string names [GROUPS];
        names = '{"in-order retire", "store commit", "branch mispredict",
                  "branch correct", "jalr correct", "jalr mispredict"};
        errors = 0;
        tests_run = 0;
        tests_failed = 0;
        new_store_cnt = 0;
        cycles = 0;
        rng = 32'd60;
        rst_n = 1'b0;
        valid_in = 1'b0;
        op_type = ooo_pkg::OP_REG;
        dest = '0;
        alu_valid = '0;
        for (int j = 0; j < `NUM_ALU; j++) begin
            alu_tag[j] = '0;
            alu_val[j] = '0;
        end
        cmp_valid = 1'b0;
        cmp_tag = '0;
        cmp_ok = 1'b0;
        cmp_val = '0;
        cmp_pc_next = '0;
        ls_valid = 1'b0;
        ls_tag = '0;
        ls_val = '0;
        ls_addr = '0;
        jalr_valid = 1'b0;
        jalr_tag = '0;
        jalr_ok = 1'b0;
        jalr_val = '0;
        jalr_pc_next = '0;
        src_tag = '0;
        mem_resp = 1'b0;
        repeat (16) @(posedge clk);
        rst_n <= 1'b1;
        @(posedge clk);
        check_val("alloc_tag after reset", 32'(alloc_tag), 1);

        for (int g = 0; g < GROUPS; g++) run_group(g, names[g]);

        // operand bypass test with the older entry held back so the younger one stays stored
        err_before = errors;
        alloc(ooo_pkg::OP_REG, 32'd20, ta);
        alloc(ooo_pkg::OP_REG, 32'd21, tb);
        push_expect(0, 20, 32'h1234, 32'(ta));
        push_expect(0, 21, 32'h5678, 32'(tb));
        @(posedge clk);
        alu_valid[1] <= 1'b1;
        alu_tag[1]   <= tb;
        alu_val[1]   <= 32'h5678;
        src_tag      <= tb;
        @(posedge clk);
        check_val("src_ready bypass", 32'(src_ready), 1);
        check_val("src_val bypass", src_val, 32'h5678);
        alu_valid <= '0;
        @(posedge clk);
        check_val("src_ready stored", 32'(src_ready), 1);
        check_val("src_val stored", src_val, 32'h5678);
        send_result(0, ta, 32'h1234, 1'b1, '0);
        drain();
        end_test("operand bypass", err_before);

        // full buffer
        err_before = errors;
        for (int i = 0; i < `ROB_DEPTH; i++) begin
            alloc(ooo_pkg::OP_REG, 32'(i + 12), full_tags[i]);
            push_expect(0, i + 12, 32'(i * 7 + 3), 32'(full_tags[i]));
        end
        @(posedge clk);
        check_val("alloc_tag full", 32'(alloc_tag), 0);
        send_result(0, full_tags[0], 32'd3, 1'b1, '0);
        // ready at this edge, retired at the next, entry free after that
        repeat (2) @(posedge clk);
        if (alloc_tag == '0) begin
            $display("ERROR t=%0t buffer still full after one retirement", $time);
            errors++;
        end
        for (int i = 1; i < `ROB_DEPTH; i++) begin
            send_result(i % 2, full_tags[i], 32'(i * 7 + 3), 1'b1, '0);
        end
        drain();
        end_test("full buffer", err_before);

        $display("tests run %0d, failed %0d, errors %0d", tests_run, tests_failed, errors);
        if (errors == 0) begin
            $display("PASS: all tests");
        end else begin
            $display("FAIL: see errors above");
        end
        $finish;
    end

endmodule
